// ==== axi_wr_pkg.sv ====
`default_nettype none

package axi_wr_pkg;

    import pcie_req_pkg::*;

    // Data buffer holds 2**BUF_ADDR_BITS beats
    localparam int BUF_ADDR_BITS = 5;

    localparam int AXI_MAX_LEN = 16;

    // Half the buffer so a burst can fill while the previous one drains
    localparam int MAX_BURST_DW = (AXI_MAX_LEN < (2 ** BUF_ADDR_BITS) / 2) ?
                                  AXI_MAX_LEN : (2 ** BUF_ADDR_BITS) / 2;

    localparam int MOT_DEPTH_BITS = 4;

    typedef logic [4:0] burst_len_t;

    typedef struct packed {
        dw_addr_t   addr;
        burst_len_t len;
        logic       np;
        token_t     token;
        logic       last;
    } burst_cmd_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
    } aw_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_beat_t;

    // Pending response record, one per issued burst
    typedef struct packed {
        logic   np;
        token_t token;
        logic   last;
    } burst_rec_t;

endpackage

`default_nettype wire

// ==== inbound_cmd_split.sv ====
`timescale 1ns/1ns
`default_nettype none

module inbound_cmd_split
    import pcie_req_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             req_h_valid,
    output logic            req_h_ready,
    input  wire req_hdr_t   req_h,
    output logic            cmd_valid,
    input  wire             cmd_ready,
    output burst_cmd_t      cmd
);

    typedef enum logic {
        S_IDLE,
        S_SPLIT
    } split_state_t;

    localparam logic [10:0] MAX_DW = 11'(MAX_BURST_DW);

    split_state_t state;

    dw_addr_t    cur_addr;
    dw_len_t     rem_len;
    logic        cur_np;
    token_t      cur_token;

    logic [10:0] dw_to_4k;
    logic [10:0] burst_dw;
    logic        last_burst;

    assign req_h_ready = (state == S_IDLE);
    assign cmd_valid   = (state == S_SPLIT);

    // Dwords left in the current 4 KB page
    assign dw_to_4k = 11'd1024 - {1'b0, cur_addr[9:0]};

    always_comb begin
        burst_dw = {1'b0, rem_len};
        if (burst_dw > MAX_DW) begin
            burst_dw = MAX_DW;
        end
        if (burst_dw > dw_to_4k) begin
            burst_dw = dw_to_4k;
        end
    end

    assign last_burst = (burst_dw == {1'b0, rem_len});

    assign cmd = '{
        addr:  cur_addr,
        len:   burst_len_t'(burst_dw),
        np:    cur_np,
        token: cur_token,
        last:  last_burst
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_h_valid) begin
                        state <= S_SPLIT;
                    end
                end
                S_SPLIT: begin
                    if (cmd_ready && last_burst) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_h_valid) begin
            cur_addr  <= req_h.addr;
            rem_len   <= req_h.len;
            cur_np    <= req_h.np;
            cur_token <= req_h.token;
        end else if (state == S_SPLIT && cmd_ready) begin
            cur_addr <= cur_addr + dw_addr_t'(burst_dw);
            rem_len  <= rem_len - dw_len_t'(burst_dw);
        end
    end

endmodule

`default_nettype wire

// ==== inbound_write.sv ====
`timescale 1ns/1ns
`default_nettype none

module inbound_write
    import pcie_req_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      cmd_valid,
    output logic                     cmd_ready,
    input  wire burst_cmd_t          cmd,

    output logic                     w_pop,
    input  wire req_data_t           w_beat,
    input  wire  [BUF_ADDR_BITS:0]   w_count,
    input  wire                      w_empty,

    output logic                     axi_aw_valid,
    input  wire                      axi_aw_ready,
    output aw_beat_t                 axi_aw,

    output logic                     axi_w_valid,
    input  wire                      axi_w_ready,
    output w_beat_t                  axi_w,

    input  wire                      axi_b_valid,
    output logic                     axi_b_ready,
    input  wire resp_t               axi_b_resp,

    output logic                     cpl_h_valid,
    input  wire                      cpl_h_ready,
    output resp_t                    cpl_h_resp,

    output logic                     err_valid,
    input  wire                      err_ready,
    output logic                     err_unsupported,

    output token_t                   token_wr
);

    // Pending burst records

    burst_rec_t b_rec;
    logic       b_full;
    logic       b_empty;
    logic       b_pop;

    sync_fifo #(
        .WIDTH      ($bits(burst_rec_t)),
        .DEPTH_BITS (MOT_DEPTH_BITS)
    ) u_pending (
        .clk        (clk),
        .rst        (rst),
        .push       (cmd_ready),
        .push_data  (burst_rec_t'{np: cmd.np, token: cmd.token, last: cmd.last}),
        .full       (b_full),
        .pop        (b_pop),
        .pop_data   (b_rec),
        .empty      (b_empty),
        .count      ()
    );

    // Burst issue

    logic                   data_first;
    burst_len_t             data_cnt;
    logic                   data_last;
    logic [BUF_ADDR_BITS:0] need_cnt;
    logic                   cmd_okay;
    burst_len_t             len_m1;

    assign data_last = (cmd.len == data_cnt);
    assign need_cnt  = (BUF_ADDR_BITS + 1)'(cmd.len);
    assign len_m1    = cmd.len - 1'b1;

    // Whole burst must already sit in the buffer
    assign cmd_okay = cmd_valid && !b_full && !w_empty && (need_cnt <= w_count);

    assign w_pop = ((!axi_aw_valid && cmd_okay) || !data_first) &&
                   (!axi_w_valid || axi_w_ready);

    assign cmd_ready = w_pop && data_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_first <= 1'b1;
            data_cnt   <= 5'd1;
        end else if (w_pop) begin
            data_first <= data_last;
            if (data_last) begin
                data_cnt <= 5'd1;
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_aw_valid <= 1'b0;
            axi_w_valid  <= 1'b0;
        end else begin
            if (axi_aw_ready) begin
                axi_aw_valid <= 1'b0;
            end
            if (axi_w_ready) begin
                axi_w_valid <= 1'b0;
            end
            if (w_pop) begin
                axi_w_valid <= 1'b1;
                if (data_first) begin
                    axi_aw_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_pop && data_first) begin
            axi_aw.addr <= {cmd.addr, 2'b00};
            axi_aw.len  <= len_m1[3:0];
        end
        if (w_pop) begin
            axi_w.data <= w_beat.data;
            axi_w.strb <= w_beat.strb;
            axi_w.last <= data_last;
        end
    end

    // Response collection

    resp_t resp;
    resp_t resp_accum;

    // Hold B off until the previous completion or error is taken
    assign axi_b_ready = !b_empty && !cpl_h_valid && !err_valid;
    assign b_pop       = axi_b_valid && axi_b_ready;

    assign resp_accum = (axi_b_resp != RESP_OKAY) ? axi_b_resp : resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp     <= RESP_OKAY;
            token_wr <= '0;
        end else if (b_pop) begin
            if (b_rec.last) begin
                resp     <= RESP_OKAY;
                token_wr <= b_rec.token;
            end else begin
                resp <= resp_accum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cpl_h_valid <= 1'b0;
            err_valid   <= 1'b0;
        end else begin
            if (cpl_h_ready) begin
                cpl_h_valid <= 1'b0;
            end
            if (err_ready) begin
                err_valid <= 1'b0;
            end
            if (b_pop && b_rec.last) begin
                cpl_h_valid <= b_rec.np;
                err_valid   <= !b_rec.np && (resp_accum != RESP_OKAY);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (b_pop && b_rec.last) begin
            cpl_h_resp      <= resp_accum;
            err_unsupported <= (resp_accum != RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

// ==== pcie_inbound_write_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_inbound_write_top
    import pcie_req_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             req_h_valid,
    output logic            req_h_ready,
    input  wire req_hdr_t   req_h,

    input  wire             req_d_valid,
    output logic            req_d_ready,
    input  wire req_data_t  req_d,

    output logic            axi_aw_valid,
    input  wire             axi_aw_ready,
    output aw_beat_t        axi_aw,

    output logic            axi_w_valid,
    input  wire             axi_w_ready,
    output w_beat_t         axi_w,

    input  wire             axi_b_valid,
    output logic            axi_b_ready,
    input  wire resp_t      axi_b,

    output logic            cpl_h_valid,
    input  wire             cpl_h_ready,
    output resp_t           cpl_h_resp,

    output logic            err_valid,
    input  wire             err_ready,
    output logic            err_unsupported,

    output token_t          token_wr
);

    burst_cmd_t             cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;

    req_data_t              w_beat;
    logic                   w_pop;
    logic                   w_empty;
    logic                   w_full;
    logic [BUF_ADDR_BITS:0] w_count;

    assign req_d_ready = !w_full;

    inbound_cmd_split u_split (
        .clk         (clk),
        .rst         (rst),
        .req_h_valid (req_h_valid),
        .req_h_ready (req_h_ready),
        .req_h       (req_h),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd)
    );

    sync_fifo #(
        .WIDTH      ($bits(req_data_t)),
        .DEPTH_BITS (BUF_ADDR_BITS)
    ) u_data_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (req_d_valid && req_d_ready),
        .push_data  (req_d),
        .full       (w_full),
        .pop        (w_pop),
        .pop_data   (w_beat),
        .empty      (w_empty),
        .count      (w_count)
    );

    inbound_write u_write (
        .clk             (clk),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .cmd             (cmd),
        .w_pop           (w_pop),
        .w_beat          (w_beat),
        .w_count         (w_count),
        .w_empty         (w_empty),
        .axi_aw_valid    (axi_aw_valid),
        .axi_aw_ready    (axi_aw_ready),
        .axi_aw          (axi_aw),
        .axi_w_valid     (axi_w_valid),
        .axi_w_ready     (axi_w_ready),
        .axi_w           (axi_w),
        .axi_b_valid     (axi_b_valid),
        .axi_b_ready     (axi_b_ready),
        .axi_b_resp      (axi_b),
        .cpl_h_valid     (cpl_h_valid),
        .cpl_h_ready     (cpl_h_ready),
        .cpl_h_resp      (cpl_h_resp),
        .err_valid       (err_valid),
        .err_ready       (err_ready),
        .err_unsupported (err_unsupported),
        .token_wr        (token_wr)
    );

endmodule

`default_nettype wire

// ==== pcie_req_pkg.sv ====
`default_nettype none

package pcie_req_pkg;

    // Request address in dwords, byte address bits 31:2
    typedef logic [29:0] dw_addr_t;

    // Request length in dwords
    typedef logic [9:0] dw_len_t;

    typedef logic [3:0] token_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        dw_addr_t addr;
        dw_len_t  len;
        logic     np;
        token_t   token;
    } req_hdr_t;

    typedef struct packed {
        logic [3:0]  strb;
        logic [31:0] data;
    } req_data_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_pcie_inbound_write -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== sim.f ====
pcie_req_pkg.sv
axi_wr_pkg.sv
sync_fifo.sv
inbound_cmd_split.sv
inbound_write.sv
pcie_inbound_write_top.sv
tb_pcie_inbound_write.sv

// ==== sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int WIDTH      = 36,
    parameter int DEPTH_BITS = 5
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  push,
    input  wire  [WIDTH-1:0]     push_data,
    output logic                 full,
    input  wire                  pop,
    output logic [WIDTH-1:0]     pop_data,
    output logic                 empty,
    output logic [DEPTH_BITS:0]  count
);

    localparam int DEPTH = 2 ** DEPTH_BITS;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = count[DEPTH_BITS];
    assign empty = (count == '0);

    // First word falls through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_pcie_inbound_write.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_inbound_write
    import pcie_req_pkg::*;
    import axi_wr_pkg::*;
();

    localparam int NUM_REQ      = 40;
    localparam int SEED         = 45663;
    localparam int MAX_CYCLES   = NUM_REQ * 64 * 8;
    localparam int DRAIN_CYCLES = 20;

    // Expected B record, one per burst in issue order
    typedef struct packed {
        logic [5:0] req;
        logic       last;
        resp_t      resp;
    } exp_b_t;

    logic      clk = 1'b0;
    logic      rst = 1'b1;

    logic      req_h_valid = 1'b0;
    logic      req_h_ready;
    req_hdr_t  req_h = '0;
    logic      req_d_valid = 1'b0;
    logic      req_d_ready;
    req_data_t req_d = '0;

    logic      axi_aw_valid;
    logic      axi_aw_ready = 1'b0;
    aw_beat_t  axi_aw;
    logic      axi_w_valid;
    logic      axi_w_ready = 1'b0;
    w_beat_t   axi_w;
    logic      axi_b_valid = 1'b0;
    logic      axi_b_ready;
    resp_t     axi_b = RESP_OKAY;

    logic      cpl_h_valid;
    logic      cpl_h_ready = 1'b0;
    resp_t     cpl_h_resp;
    logic      err_valid;
    logic      err_ready = 1'b0;
    logic      err_unsupported;
    token_t    token_wr;

    req_hdr_t  hdr [NUM_REQ];
    resp_t     req_final [NUM_REQ];
    req_data_t data_q [$];
    aw_beat_t  aw_q [$];
    w_beat_t   w_q [$];
    exp_b_t    b_q [$];
    int        cpl_q [$];
    int        err_q [$];

    int        h_idx = 0;
    int        d_idx = 0;
    int        aw_cnt = 0;
    int        wl_cnt = 0;
    int        b_cnt = 0;
    int        finished = 0;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        tok_req = 0;
    logic      tok_pend = 1'b0;
    logic      generated = 1'b0;
    resp_t     acc_resp = RESP_OKAY;

    pcie_inbound_write_top DUT (
        .clk             (clk),
        .rst             (rst),
        .req_h_valid     (req_h_valid),
        .req_h_ready     (req_h_ready),
        .req_h           (req_h),
        .req_d_valid     (req_d_valid),
        .req_d_ready     (req_d_ready),
        .req_d           (req_d),
        .axi_aw_valid    (axi_aw_valid),
        .axi_aw_ready    (axi_aw_ready),
        .axi_aw          (axi_aw),
        .axi_w_valid     (axi_w_valid),
        .axi_w_ready     (axi_w_ready),
        .axi_w           (axi_w),
        .axi_b_valid     (axi_b_valid),
        .axi_b_ready     (axi_b_ready),
        .axi_b           (axi_b),
        .cpl_h_valid     (cpl_h_valid),
        .cpl_h_ready     (cpl_h_ready),
        .cpl_h_resp      (cpl_h_resp),
        .err_valid       (err_valid),
        .err_ready       (err_ready),
        .err_unsupported (err_unsupported),
        .token_wr        (token_wr)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        errors = errors + 1;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    // Roughly one burst in four fails
    function automatic resp_t pick_response();
        int r;
        r = int'($urandom % 8);
        if (r == 0) begin
            return RESP_SLVERR;
        end
        if (r == 1) begin
            return RESP_DECERR;
        end
        return RESP_OKAY;
    endfunction

    // Bursts stop at the 4 KB page end and at MAX_BURST_DW beats
    task automatic split_request(input int idx);
        dw_addr_t  a;
        int        rem;
        int        blen;
        int        to4k;
        int        i;
        aw_beat_t  aw;
        w_beat_t   wb;
        req_data_t d;
        exp_b_t    br;
        a   = hdr[idx].addr;
        rem = int'(hdr[idx].len);
        while (rem > 0) begin
            to4k = 1024 - int'(a[9:0]);
            blen = rem;
            if (blen > MAX_BURST_DW) begin
                blen = MAX_BURST_DW;
            end
            if (blen > to4k) begin
                blen = to4k;
            end
            aw.addr = {a, 2'b00};
            aw.len  = 4'(blen - 1);
            aw_q.push_back(aw);
            for (i = 0; i < blen; i = i + 1) begin
                d.data = $urandom;
                d.strb = 4'($urandom);
                data_q.push_back(d);
                wb.data = d.data;
                wb.strb = d.strb;
                wb.last = (i == blen - 1);
                w_q.push_back(wb);
            end
            br.req  = 6'(idx);
            br.last = (rem == blen);
            br.resp = pick_response();
            b_q.push_back(br);
            a   = a + dw_addr_t'(blen);
            rem = rem - blen;
        end
    endtask

    task automatic build_stimulus;
        int          i;
        logic [10:0] off;
        for (i = 0; i < NUM_REQ; i = i + 1) begin
            // Start a few dwords below a page boundary
            off          = 11'd1024 - 11'($urandom % 48);
            hdr[i].addr  = {20'($urandom), off[9:0]};
            hdr[i].len   = dw_len_t'(1 + $urandom % 64);
            hdr[i].np    = 1'($urandom % 2);
            hdr[i].token = token_t'($urandom);
            split_request(i);
        end
        generated = 1'b1;
    endtask

    task automatic close_request(input int idx);
        finished = finished + 1;
        $display("Request %0d finished at %0t: addr %h len %0d np %0b token %h resp %0d, errors %0d",
                 idx, $time, {hdr[idx].addr, 2'b00}, hdr[idx].len, hdr[idx].np,
                 hdr[idx].token, req_final[idx], errors);
    endtask

    task automatic match_aw;
        aw_beat_t exp;
        if (axi_aw_valid && axi_aw_ready) begin
            checks = checks + 1;
            aw_cnt = aw_cnt + 1;
            if (aw_q.size() == 0) begin
                report_failure("AW burst issued with no burst expected");
            end else begin
                exp = aw_q.pop_front();
                if (axi_aw !== exp) begin
                    report_failure($sformatf("AW addr %h len %0d, expected addr %h len %0d",
                                             axi_aw.addr, axi_aw.len, exp.addr, exp.len));
                end
            end
            if (int'(axi_aw.addr[11:0]) + 4 * (int'(axi_aw.len) + 1) > 4096) begin
                report_failure($sformatf("AW burst at %h crosses a 4 KB boundary", axi_aw.addr));
            end
        end
    endtask

    task automatic match_w;
        w_beat_t exp;
        if (axi_w_valid && axi_w_ready) begin
            checks = checks + 1;
            if (w_q.size() == 0) begin
                report_failure("W beat sent with no beat expected");
            end else begin
                exp = w_q.pop_front();
                if (axi_w !== exp) begin
                    report_failure($sformatf("W data %h strb %h last %0b, expected %h %h %0b",
                                             axi_w.data, axi_w.strb, axi_w.last,
                                             exp.data, exp.strb, exp.last));
                end
                if (exp.last) begin
                    wl_cnt = wl_cnt + 1;
                end
            end
        end
    endtask

    task automatic collect_b;
        exp_b_t rec;
        if (axi_b_valid && axi_b_ready) begin
            rec   = b_q[b_cnt];
            b_cnt = b_cnt + 1;
            if (rec.resp != RESP_OKAY) begin
                acc_resp = rec.resp;
            end
            if (rec.last) begin
                tok_req            = int'(rec.req);
                tok_pend           = 1'b1;
                req_final[tok_req] = acc_resp;
                acc_resp           = RESP_OKAY;
                if (hdr[tok_req].np) begin
                    cpl_q.push_back(tok_req);
                end else if (req_final[tok_req] != RESP_OKAY) begin
                    err_q.push_back(tok_req);
                end
            end
        end
    endtask

    // Token lands one cycle after the last B of a request
    task automatic verify_token;
        if (tok_pend) begin
            tok_pend = 1'b0;
            checks   = checks + 1;
            if (token_wr !== hdr[tok_req].token) begin
                report_failure($sformatf("token_wr %h after request %0d, expected %h",
                                         token_wr, tok_req, hdr[tok_req].token));
            end
            if (!hdr[tok_req].np && req_final[tok_req] == RESP_OKAY) begin
                close_request(tok_req);
            end
        end
    endtask

    task automatic accept_completion;
        int r;
        if (cpl_h_valid && cpl_h_ready) begin
            checks = checks + 1;
            if (cpl_q.size() == 0) begin
                report_failure("completion raised with no non-posted request waiting");
            end else begin
                r = cpl_q.pop_front();
                if (cpl_h_resp !== req_final[r] || token_wr !== hdr[r].token) begin
                    report_failure($sformatf("completion resp %0d token %h, expected %0d %h",
                                             cpl_h_resp, token_wr, req_final[r], hdr[r].token));
                end
                close_request(r);
            end
        end
    endtask

    task automatic accept_error;
        int r;
        if (err_valid && err_ready) begin
            checks = checks + 1;
            if (err_q.size() == 0) begin
                report_failure("error raised with no failed posted request waiting");
            end else begin
                r = err_q.pop_front();
                if (err_unsupported !== 1'b1 || token_wr !== hdr[r].token) begin
                    report_failure($sformatf("error unsupported %0b token %h, expected 1 %h",
                                             err_unsupported, token_wr, hdr[r].token));
                end
                close_request(r);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (rst) begin
            if (!generated) begin
                build_stimulus();
            end
        end else begin
            verify_token();
            match_aw();
            match_w();
            collect_b();
            accept_completion();
            accept_error();

            if (req_h_valid && req_h_ready) begin
                h_idx = h_idx + 1;
            end
            if (!req_h_valid || req_h_ready) begin
                if (h_idx < NUM_REQ && ($urandom % 4) != 0) begin
                    req_h_valid <= 1'b1;
                    req_h       <= hdr[h_idx];
                end else begin
                    req_h_valid <= 1'b0;
                end
            end

            if (req_d_valid && req_d_ready) begin
                d_idx = d_idx + 1;
            end
            if (!req_d_valid || req_d_ready) begin
                if (d_idx < data_q.size() && ($urandom % 4) != 0) begin
                    req_d_valid <= 1'b1;
                    req_d       <= data_q[d_idx];
                end else begin
                    req_d_valid <= 1'b0;
                end
            end

            axi_aw_ready <= ($urandom % 4) != 0;
            axi_w_ready  <= ($urandom % 4) != 0;
            cpl_h_ready  <= ($urandom % 4) != 0;
            err_ready    <= ($urandom % 4) != 0;

            // Slave answers a burst once its AW and last W are both taken
            if (!axi_b_valid || axi_b_ready) begin
                if (b_cnt < aw_cnt && b_cnt < wl_cnt && b_cnt < b_q.size() &&
                    ($urandom % 4) != 0) begin
                    axi_b_valid <= 1'b1;
                    axi_b       <= b_q[b_cnt].resp;
                end else begin
                    axi_b_valid <= 1'b0;
                end
            end
        end
    end

    initial begin
        int seed_out;
        int end_errors;
        seed_out   = $urandom(SEED);
        end_errors = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (finished < NUM_REQ && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (finished < NUM_REQ) begin
            $display("Timeout after %0d cycles with %0d of %0d requests finished",
                     cycles, finished, NUM_REQ);
            end_errors = end_errors + 1;
        end else begin
            repeat (DRAIN_CYCLES) @(posedge clk);
            if (aw_q.size() != 0 || w_q.size() != 0 || b_cnt != b_q.size() ||
                cpl_q.size() != 0 || err_q.size() != 0) begin
                $display("Outputs missing at end of run: %0d AW, %0d W, %0d B, %0d cpl, %0d err",
                         aw_q.size(), w_q.size(), b_q.size() - b_cnt,
                         cpl_q.size(), err_q.size());
                end_errors = end_errors + 1;
            end
        end
        $display("Requests finished %0d of %0d, checks %0d, errors %0d",
                 finished, NUM_REQ, checks, errors + end_errors);
        if (errors + end_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
